/* design/cpuPkg.sv */
package cpuPkg;

	////////////////////////////////////////
	// Widths and base types
	////////////////////////////////////////
	localparam int wordW = 32;                   // Data and address width
	localparam int regAddrW = 5;                 // Register index width

	typedef logic [wordW-1:0] wordT;
	typedef logic [regAddrW-1:0] regAddrT;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opAddi  = 6'b001000,
		opAddiu = 6'b001001,
		opSlti  = 6'b001010,
		opSltiu = 6'b001011,
		opAndi  = 6'b001100,
		opOri   = 6'b001101,
		opXori  = 6'b001110,
		opLui   = 6'b001111,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd  = 6'b100000,
		fnAddu = 6'b100001,
		fnSub  = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010,
		fnSltu = 6'b101011
	} funcT;

	// ALU operation codes, same values as the old ALU control
	typedef enum logic [3:0] {
		aluAnd  = 4'b0000,
		aluOr   = 4'b0001,
		aluAdd  = 4'b0010,
		aluSub  = 4'b0110,
		aluSlt  = 4'b0111,
		aluAddu = 4'b1000,
		aluSubu = 4'b1001,
		aluXor  = 4'b1010,
		aluSltu = 4'b1011,
		aluNor  = 4'b1100,
		aluLui  = 4'b1110
	} aluOpT;

	// R-type layout, low 16 bits double as immediate, low 26 as jump field
	typedef struct packed {
		opcodeT opcode;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		logic [4:0] shamt;                   // Unused, no shifts
		funcT func;
	} instrT;

endpackage

/* design/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf
	import cpuPkg::*;
();
	logic regDst;                                // 1 = rd, 0 = rt
	logic aluSrc;                                // 1 = immediate operand
	logic memToReg;                              // Writeback from memory
	logic regWrite;
	logic memWrite;
	logic branch;
	logic jump;
	logic signExtend;                            // Sign vs zero extension of imm16
	aluOpT aluOp;

	modport decoder (
		output regDst, aluSrc, memToReg, regWrite, memWrite,
		output branch, jump, signExtend, aluOp
	);
	modport pcSide (input branch, jump);
	modport exec (input aluSrc, signExtend, aluOp);
	modport datapath (input regDst, memToReg, regWrite, memWrite);

endinterface

/* design/pcCounter.sv */
`timescale 1ns/1ps

module pcCounter
	import cpuPkg::*;
(
	input  logic Clock,
	input  logic rstN,
	input  wordT startPc,
	ctrlIf.pcSide ctrl,
	input  logic aluZero,
	input  logic [25:0] jumpField,
	input  wordT branchOffset,
	output wordT pc
);

	wordT pcPlus4;
	wordT nextPc;

	assign pcPlus4 = pc + wordW'(4);

	always_comb begin
		if (ctrl.jump) begin
			nextPc = {pcPlus4[31:28], jumpField, 2'b00};   // Region of pc+4
		end else if (ctrl.branch && aluZero) begin
			nextPc = pcPlus4 + (branchOffset << 2);        // Taken beq
		end else begin
			nextPc = pcPlus4;                              // Sequential
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN)
			pc <= startPc;                                 // Fetch start
		else
			pc <= nextPc;
	end

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
	import cpuPkg::*;
(
	input  instrT instr,
	ctrlIf.decoder ctrl
);

	always_comb begin
		// Defaults give a no-op
		ctrl.regDst = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.signExtend = 1'b0;
		ctrl.aluOp = aluAdd;

		case (instr.opcode)
			opRType: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;                // Cleared below for unknown func
				case (instr.func)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnAddu:  ctrl.aluOp = aluAddu;
					fnSub:   ctrl.aluOp = aluSub;
					fnSubu:  ctrl.aluOp = aluSubu;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnXor:   ctrl.aluOp = aluXor;
					fnNor:   ctrl.aluOp = aluNor;
					fnSlt:   ctrl.aluOp = aluSlt;
					fnSltu:  ctrl.aluOp = aluSltu;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opLw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;                // Base plus zero-extended offset
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.signExtend = 1'b1;              // Offset is signed
				ctrl.aluOp = aluSub;                 // Equal when difference is zero
			end
			opJ: ctrl.jump = 1'b1;
			opAddi, opAddiu, opSlti, opLui,
			opAndi, opOri, opXori, opSltiu: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.signExtend = instr.opcode inside {opAddi, opAddiu, opSlti, opLui};
				case (instr.opcode)
					opAddi:  ctrl.aluOp = aluAdd;
					opAddiu: ctrl.aluOp = aluAddu;
					opSlti:  ctrl.aluOp = aluSlt;
					opLui:   ctrl.aluOp = aluLui;
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					opXori:  ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluSltu;   // sltiu
				endcase
			end
			default: ;                               // Unknown opcode, no writes
		endcase
	end

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ps

module registerFile
	import cpuPkg::*;
(
	input  logic Clock,
	input  logic rstN,
	input  regAddrT readA,
	input  regAddrT readB,
	input  regAddrT writeAddr,
	input  logic writeEn,
	input  wordT writeData,
	output wordT busA,
	output wordT busB
);

	localparam int numRegs = 2 ** regAddrW;

	wordT regs [numRegs];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;                       // Whole file cleared
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;            // $0 never written
		end
	end

	// Combinational reads, $0 forced to zero
	assign busA = (readA == '0) ? '0 : regs[readA];
	assign busB = (readB == '0) ? '0 : regs[readB];

endmodule

/* design/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit
	import cpuPkg::*;
(
	ctrlIf.exec ctrl,
	input  wordT busA,
	input  wordT busB,
	input  logic [15:0] imm16,
	output wordT extImm,
	output wordT result,
	output logic zero
);

	wordT opB;
	logic extBit;

	////////////////////////////////////////
	// Operand path
	////////////////////////////////////////
	assign extBit = ctrl.signExtend & imm16[15];     // Zero fill when not signed
	assign extImm = {{16{extBit}}, imm16};
	assign opB = ctrl.aluSrc ? extImm : busB;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			aluAnd:  result = busA & opB;
			aluOr:   result = busA | opB;
			aluAdd:  result = busA + opB;            // No overflow trap
			aluSub:  result = busA - opB;
			aluAddu: result = busA + opB;
			aluSubu: result = busA - opB;
			aluXor:  result = busA ^ opB;
			aluNor:  result = ~(busA | opB);
			aluSlt:  result = wordW'($signed(busA) < $signed(opB));
			aluSltu: result = wordW'(busA < opB);
			aluLui:  result = {opB[15:0], 16'h0000}; // Imm to upper half
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);                    // beq compare

endmodule

/* design/wordMemory.sv */
`timescale 1ns/1ps

module wordMemory
	import cpuPkg::*;
#(
	parameter int depth = 64,
	parameter type elemT = wordT
) (
	input  logic Clock,
	input  logic writeEn,
	input  wordT writeAddr,
	input  elemT writeData,
	input  wordT readAddr,
	output elemT readData
);

	elemT mem [depth];
	wordT writeIdx;
	wordT readIdx;

	// Byte address to word index, wraps at depth
	assign writeIdx = (writeAddr >> 2) % depth;
	assign readIdx = (readAddr >> 2) % depth;

	always_ff @(posedge Clock) begin
		if (writeEn)
			mem[writeIdx] <= writeData;
	end

	assign readData = mem[readIdx];                  // Asynchronous read

endmodule

/* design/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
	import cpuPkg::*;
#(
	parameter int imemDepth = 64,
	parameter int dmemDepth = 64
) (
	input  logic Clock,
	input  logic rstN,
	input  wordT startPc,
	input  logic progWe,
	input  wordT progAddr,
	input  instrT progData,
	output wordT pc,
	output wordT dMemOut
);

	instrT instr;
	wordT busA, busB, busW;
	wordT extImm, aluResult, loadWord;
	logic aluZero;
	regAddrT destReg;
	logic storeEn;

	ctrlIf ctrl ();

	////////////////////////////////////////
	// Fetch and decode
	////////////////////////////////////////
	pcCounter uPc (
		.Clock(Clock), .rstN(rstN), .startPc(startPc), .ctrl(ctrl.pcSide),
		.aluZero(aluZero), .jumpField(instr[25:0]), .branchOffset(extImm), .pc(pc)
	);

	// Loaded through the prog port, read at pc
	wordMemory #(.depth(imemDepth), .elemT(instrT)) uImem (
		.Clock(Clock), .writeEn(progWe), .writeAddr(progAddr), .writeData(progData),
		.readAddr(pc), .readData(instr)
	);

	instrDecoder uDec (.instr(instr), .ctrl(ctrl.decoder));

	////////////////////////////////////////
	// Register read, execute, memory
	////////////////////////////////////////
	assign destReg = ctrl.regDst ? instr.rd : instr.rt;  // R-type uses rd

	registerFile uRegs (
		.Clock(Clock), .rstN(rstN), .readA(instr.rs), .readB(instr.rt),
		.writeAddr(destReg), .writeEn(ctrl.regWrite), .writeData(busW),
		.busA(busA), .busB(busB)
	);

	executeUnit uExec (
		.ctrl(ctrl.exec), .busA(busA), .busB(busB), .imm16(instr[15:0]),
		.extImm(extImm), .result(aluResult), .zero(aluZero)
	);

	assign storeEn = ctrl.memWrite & rstN;           // Nothing retires in reset

	wordMemory #(.depth(dmemDepth), .elemT(wordT)) uDmem (
		.Clock(Clock), .writeEn(storeEn), .writeAddr(aluResult), .writeData(busB),
		.readAddr(aluResult), .readData(loadWord)
	);

	assign busW = ctrl.memToReg ? loadWord : aluResult;  // Writeback select

	// Last loaded word, held until next lw
	always_ff @(posedge Clock) begin
		if (!rstN)
			dMemOut <= '0;
		else if (ctrl.memToReg)
			dMemOut <= loadWord;
	end

endmodule

/* test/cpuTop_props.sv */
`timescale 1ns/1ps

module cpuTop_props
	import cpuPkg::*;
(
	input logic Clock,
	input logic rstN,
	input wordT startPc,
	input logic branch,
	input logic jump,
	input wordT pc
);

	// Reset edge loads the start address
	resetLoad: assert property (@(posedge Clock) !rstN |=> pc == $past(startPc))
		else $error("pc did not take startPc after a reset edge");

	// Release edge still reloads startPc, so only edges with rstN high retire
	seqStep: assert property (@(posedge Clock) disable iff (!rstN)
		(rstN && !branch && !jump) |=> pc == $past(pc) + 32'd4)  // Straight-line code
		else $error("pc did not advance by four without branch or jump");

	wordAligned: assert property (@(posedge Clock) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc is not word aligned");

endmodule

bind pcCounter cpuTop_props props (
	.Clock(Clock), .rstN(rstN), .startPc(startPc), .branch(ctrl.branch),
	.jump(ctrl.jump), .pc(pc)
);

/* test/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb
	import cpuPkg::*;
();

	typedef struct packed {
		instrT instr;
		wordT expPc;                                 // pc once the instruction retires
		logic checkMem;
		wordT expMem;
	} stepT;

	localparam int waitLimit = 20;                   // Cycles allowed per wait

	logic Clock;
	logic rstN;
	wordT startPc;
	logic progWe;
	wordT progAddr;
	instrT progData;
	wordT pc;
	wordT dMemOut;

	stepT steps [$];                                 // Program in execution order
	int valueErrors;
	int timeouts;
	int cycleCount = 0;                              // Rising edges seen
	wordT loadAddr;

	// Program with its jump target runs past 64 words
	cpuTop #(.imemDepth(128), .dmemDepth(64)) dut (
		.Clock(Clock), .rstN(rstN), .startPc(startPc), .progWe(progWe),
		.progAddr(progAddr), .progData(progData), .pc(pc), .dMemOut(dMemOut)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;                   // 10 ns period
	end

	always @(posedge Clock)
		cycleCount <= cycleCount + 1;

	////////////////////////////////////////
	// Instruction encoders and table build
	////////////////////////////////////////
	function automatic instrT rType(funcT fn, regAddrT rs, regAddrT rt, regAddrT rd);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instrT iType(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrT jType(logic [25:0] target);
		return {opJ, target};
	endfunction

	// Straight-line step, next pc is this one plus four
	task automatic addSeq(instrT instr, logic checkMem, wordT expMem);
		wordT prevPc;
		prevPc = (steps.size() == 0) ? startPc : steps[$].expPc;
		steps.push_back(stepT'{instr, prevPc + 32'd4, checkMem, expMem});
	endtask

	task automatic addFlow(instrT instr, wordT target, logic checkMem, wordT expMem);
		steps.push_back(stepT'{instr, target, checkMem, expMem});
	endtask

	// sw rt,off($0) then lw $20,off($0)
	task automatic storeLoad(regAddrT rt, logic [15:0] off, wordT expected);
		addSeq(iType(opSw, 5'd0, rt, off), 1'b0, '0);
		addSeq(iType(opLw, 5'd0, 5'd20, off), 1'b1, expected);
	endtask

	task automatic buildProgram();
		addSeq(iType(opLui, 5'd0, 5'd1, 16'h8000), 1'b0, '0);      // $1 = 0x80000000
		addSeq(iType(opOri, 5'd1, 5'd1, 16'h0005), 1'b0, '0);      // $1 = 0x80000005
		addSeq(iType(opOri, 5'd0, 5'd2, 16'h0003), 1'b0, '0);      // $2 = 3
		// R-type into $3, all through word 0
		addSeq(rType(fnAdd, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h80000008);
		addSeq(rType(fnSub, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h80000002);
		addSeq(rType(fnAnd, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h00000001);
		addSeq(rType(fnOr, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h80000007);
		addSeq(rType(fnXor, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h80000006);
		addSeq(rType(fnNor, 5'd1, 5'd2, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h7ffffff8);
		addSeq(rType(fnSlt, 5'd1, 5'd2, 5'd3), 1'b0, '0);          // Negative < 3
		storeLoad(5'd3, 16'h0000, 32'h00000001);
		addSeq(rType(fnSltu, 5'd1, 5'd2, 5'd3), 1'b0, '0);         // Large unsigned
		storeLoad(5'd3, 16'h0000, 32'h00000000);
		addSeq(rType(fnAddu, 5'd1, 5'd1, 5'd3), 1'b0, '0);         // Carry out dropped
		storeLoad(5'd3, 16'h0000, 32'h0000000a);
		addSeq(rType(fnSubu, 5'd2, 5'd1, 5'd3), 1'b0, '0);
		storeLoad(5'd3, 16'h0000, 32'h7ffffffe);
		// Immediates into $6, all through word 1
		addSeq(iType(opAddi, 5'd0, 5'd6, 16'hfffc), 1'b0, '0);     // -4
		storeLoad(5'd6, 16'h0004, 32'hfffffffc);
		addSeq(iType(opSlti, 5'd2, 5'd6, 16'hffff), 1'b0, '0);     // 3 < -1 is false
		storeLoad(5'd6, 16'h0004, 32'h00000000);
		addSeq(iType(opAndi, 5'd1, 5'd6, 16'hffff), 1'b0, '0);
		storeLoad(5'd6, 16'h0004, 32'h00000005);
		addSeq(iType(opOri, 5'd0, 5'd6, 16'h8001), 1'b0, '0);
		storeLoad(5'd6, 16'h0004, 32'h00008001);
		addSeq(iType(opXori, 5'd1, 5'd6, 16'h8000), 1'b0, '0);
		storeLoad(5'd6, 16'h0004, 32'h80008005);
		addSeq(iType(opSltiu, 5'd1, 5'd6, 16'h8000), 1'b0, '0);    // Imm is 0x8000 unsigned
		storeLoad(5'd6, 16'h0004, 32'h00000000);
		addSeq(iType(opLui, 5'd0, 5'd6, 16'h1234), 1'b0, '0);
		storeLoad(5'd6, 16'h0004, 32'h12340000);
		// Two addresses, dMemOut held across stores
		addSeq(iType(opSw, 5'd0, 5'd2, 16'h0088), 1'b1, 32'h12340000);
		addSeq(iType(opSw, 5'd0, 5'd1, 16'h008c), 1'b1, 32'h12340000);
		addSeq(iType(opLw, 5'd0, 5'd21, 16'h0088), 1'b1, 32'h00000003);
		addSeq(iType(opLw, 5'd0, 5'd21, 16'h008c), 1'b1, 32'h80000005);
		addSeq(iType(opAddi, 5'd0, 5'd0, 16'h0077), 1'b1, 32'h80000005);  // $0 stays 0
		storeLoad(5'd0, 16'h0088, 32'h00000000);
		// Control flow from 0xf4
		addFlow(iType(opBeq, 5'd2, 5'd2, 16'h0001), 32'h000000fc, 1'b1, '0);  // Skips 0xf8
		addSeq(iType(opBeq, 5'd1, 5'd2, 16'h0005), 1'b1, '0);      // Not taken
		addFlow(jType(26'h0000042), 32'h00000108, 1'b1, '0);       // Skips 0x104
		addSeq(iType(opLw, 5'd0, 5'd21, 16'h0000), 1'b1, 32'h7ffffffe);
	endtask

	////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////
	task automatic checkWord(string name, wordT expected, wordT actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, got %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	// Returns on the falling edge once target rising edges have passed
	task automatic waitCycle(int target, output logic timedOut);
		int guard;
		guard = 0;
		timedOut = 1'b0;
		while (cycleCount < target && !timedOut) begin
			@(negedge Clock);
			guard++;
			if (guard > waitLimit) begin
				$display("Timeout: clock edge %0d not reached within %0d cycles", target, waitLimit);
				timeouts++;
				timedOut = 1'b1;
			end
		end
	endtask

	initial begin
		logic timedOut;
		int target;
		rstN = 1'b0;
		startPc = '0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		valueErrors = 0;
		timeouts = 0;
		buildProgram();

		// Each word goes where it is fetched from
		loadAddr = startPc;
		for (int i = 0; i < steps.size(); i++) begin
			@(posedge Clock);
			progWe <= 1'b1;
			progAddr <= loadAddr;
			progData <= steps[i].instr;
			loadAddr = steps[i].expPc;
		end
		@(posedge Clock);
		progWe <= 1'b0;
		@(negedge Clock);
		target = cycleCount + 2;                     // Two more reset cycles
		waitCycle(target, timedOut);
		target = cycleCount + 1;
		@(posedge Clock);
		rstN <= 1'b1;                                // Release edge still loads startPc
		if (!timedOut)
			waitCycle(target, timedOut);
		if (!timedOut) begin
			checkWord("pc after reset", startPc, pc);
			checkWord("dMemOut after reset", '0, dMemOut);
		end

		// One instruction retires per edge
		for (int i = 0; i < steps.size() && !timedOut; i++) begin
			target = cycleCount + 1;
			waitCycle(target, timedOut);
			if (!timedOut) begin
				checkWord($sformatf("pc step %0d", i), steps[i].expPc, pc);
				if (steps[i].checkMem)
					checkWord($sformatf("dMemOut step %0d", i), steps[i].expMem, dMemOut);
			end
		end

		$display("Errors: %0d value mismatches, %0d timeouts", valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
design/cpuPkg.sv
design/ctrlIf.sv
design/pcCounter.sv
design/instrDecoder.sv
design/registerFile.sv
design/executeUnit.sv
design/wordMemory.sv
design/cpuTop.sv
test/cpuTop_props.sv
test/cpuTb.sv

/* Makefile */
TOP ?= cpuTb
SIM_ARGS ?=
LOG ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST ?= verilog.f
VERILATOR ?= verilator
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# A run stopped by an assertion has no closing line, so its exit status counts too
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
